// ==== verilog/eth_pkg.sv ====
package eth_pkg;

    // ********************
    // width types
    // ********************
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] byte_cnt_t;    // byte counts and length fields
    typedef logic [31:0] tx_word_t;     // msb goes out first
    typedef logic [31:0] crc_t;

    // one gmii transmit beat
    typedef struct packed {
        logic       en;
        logic [7:0] data;
    } gmii_tx_t;

    // frame builder sections, in wire order after csum
    typedef enum logic [3:0] {
        ST_IDLE,
        ST_CSUM,        // waiting on ip header checksum
        ST_PREAMBLE,
        ST_MAC_HDR,
        ST_IP_HDR,
        ST_UDP_HDR,
        ST_PAYLOAD,
        ST_PAD,
        ST_FCS,
        ST_GAP          // interframe gap
    } tx_state_t;

    // ********************
    // fixed addressing
    // ********************
    localparam mac_addr_t BOARD_MAC  = 48'h12_34_56_78_9a_bc;
    localparam mac_addr_t DES_MAC    = 48'hff_ff_ff_ff_ff_ff;     // broadcast
    localparam ip_addr_t  BOARD_IP   = {8'd192, 8'd168, 8'd0, 8'd234};
    localparam ip_addr_t  DES_IP     = {8'd192, 8'd168, 8'd0, 8'd145};
    localparam byte_cnt_t BOARD_PORT = 16'd1234;
    localparam byte_cnt_t DES_PORT   = 16'd1234;

    // ********************
    // frame format
    // ********************
    localparam byte_cnt_t MIN_PAYLOAD  = 16'd18;  // 28 + 18 = 46 bytes min frame data
    localparam byte_cnt_t IFG_CYCLES   = 16'd12;
    localparam byte_cnt_t PREAMBLE_LEN = 16'd8;   // incl sfd
    localparam byte_cnt_t MAC_HDR_LEN  = 16'd14;
    localparam byte_cnt_t IP_HDR_LEN   = 16'd20;
    localparam byte_cnt_t UDP_HDR_LEN  = 16'd8;
    localparam byte_cnt_t FCS_LEN      = 16'd4;

    localparam logic [7:0]  PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0]  SFD_BYTE      = 8'hd5;
    localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_VER_IHL    = 8'h45;   // v4, 5 words
    localparam logic [15:0] IP_FLAGS      = 16'h4000; // don't fragment
    localparam logic [7:0]  IP_TTL        = 8'd64;
    localparam logic [7:0]  IP_PROTO_UDP  = 8'd17;

    // reflected crc-32
    localparam crc_t CRC_INIT = 32'hffff_ffff;
    localparam crc_t CRC_POLY = 32'hedb8_8320;

endpackage

// ==== verilog/crc32_d8.sv ====
module crc32_d8 (
    input  logic          gmii_tx_clk,
    input  logic          reset,
    input  logic          clear,        // restart at all ones
    input  logic          data_valid,
    input  logic [7:0]    data,
    output eth_pkg::crc_t crc           // fcs value, send lsb byte first
);
    import eth_pkg::*;

    crc_t crc_q;      // running remainder, reflected
    crc_t crc_nxt;

    // ********************
    // byte update
    // ********************
    // lsb-first shift, one bit per iteration
    always_comb begin
        crc_nxt = crc_q ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            if (crc_nxt[0]) begin
                crc_nxt = (crc_nxt >> 1) ^ CRC_POLY;
            end else begin
                crc_nxt = crc_nxt >> 1;
            end
        end
    end

    always_ff @(posedge gmii_tx_clk) begin
        if (reset || clear) begin
            crc_q <= CRC_INIT;
        end else if (data_valid) begin
            crc_q <= crc_nxt;       // hold when no byte
        end
    end

    // reflected register already holds wire bit order
    // so only the final inversion is left
    assign crc = ~crc_q;

endmodule

// ==== verilog/ip_checksum.sv ====
module ip_checksum (
    input  logic               gmii_tx_clk,
    input  logic               reset,
    input  logic               start,
    input  eth_pkg::byte_cnt_t total_len,   // ip total length field
    input  logic [15:0]        ident,
    output logic [15:0]        csum,
    output logic               csum_valid   // 12 cycles after start
);
    import eth_pkg::*;

    logic        busy;
    logic [3:0]  step;      // 1..10 add halfword, 11 finish
    byte_cnt_t   len_q;
    logic [15:0] ident_q;
    logic [19:0] sum;       // 10 halfwords never pass 20 bits
    logic [15:0] hword;
    logic [16:0] fold1;
    logic [15:0] fold2;

    // header halfwords in order
    always_comb begin
        case (step)
            4'd1:    hword = {IP_VER_IHL, 8'h00};      // tos 0
            4'd2:    hword = len_q;
            4'd3:    hword = ident_q;
            4'd4:    hword = IP_FLAGS;
            4'd5:    hword = {IP_TTL, IP_PROTO_UDP};
            4'd6:    hword = 16'h0000;                 // the checksum field itself
            4'd7:    hword = BOARD_IP[31:16];
            4'd8:    hword = BOARD_IP[15:0];
            4'd9:    hword = DES_IP[31:16];
            4'd10:   hword = DES_IP[15:0];
            default: hword = 16'h0000;
        endcase
    end

    // end-around carry, second fold catches the carry of the first
    assign fold1 = {1'b0, sum[15:0]} + {13'd0, sum[19:16]};
    assign fold2 = fold1[15:0] + {15'd0, fold1[16]};

    // ********************
    // sequencer
    // ********************
    always_ff @(posedge gmii_tx_clk) begin
        if (reset) begin
            busy       <= 1'b0;
            step       <= 4'd0;
            csum_valid <= 1'b0;
        end else begin
            csum_valid <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                step <= 4'd1;
            end else if (busy) begin
                if (step == 4'd11) begin
                    busy       <= 1'b0;
                    step       <= 4'd0;
                    csum_valid <= 1'b1;
                end else begin
                    step <= step + 4'd1;
                end
            end
        end
    end

    // accumulator and result
    always_ff @(posedge gmii_tx_clk) begin
        if (start) begin
            len_q   <= total_len;
            ident_q <= ident;
            sum     <= '0;
        end else if (busy && step <= 4'd10) begin
            sum <= sum + {4'd0, hword};
        end
        if (busy && step == 4'd11) begin
            csum <= ~fold2;
        end
    end

    // builder waits for csum_valid before asking again
    assert property (@(posedge gmii_tx_clk) disable iff (reset) start |-> !busy)
        else $error("ip_checksum restarted mid-sum");

endmodule

// ==== verilog/tx_word_fifo.sv ====
module tx_word_fifo #(
    parameter int DEPTH = 512
) (
    input  logic              gmii_tx_clk,
    input  logic              reset,
    input  logic              wr_en,
    input  eth_pkg::tx_word_t wr_data,
    output logic              wr_full,
    input  logic              rd_en,
    output eth_pkg::tx_word_t rd_data,    // valid the cycle after rd_en
    output logic              rd_empty
);
    import eth_pkg::*;

    tx_word_t                     mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]     wr_ptr;
    logic [$clog2(DEPTH)-1:0]     rd_ptr;
    logic [$clog2(DEPTH + 1)-1:0] count;   // occupancy
    logic                         wr_accept;
    logic                         rd_accept;

    // wrap for any depth, not only powers of two
    function automatic logic [$clog2(DEPTH)-1:0] next_ptr(
        input logic [$clog2(DEPTH)-1:0] ptr
    );
        if (ptr == ($clog2(DEPTH))'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign wr_full   = (count == ($clog2(DEPTH + 1))'(DEPTH));
    assign rd_empty  = (count == '0);
    assign wr_accept = wr_en && !wr_full;   // write while full is dropped
    assign rd_accept = rd_en && !rd_empty;

    // ********************
    // pointers and count
    // ********************
    always_ff @(posedge gmii_tx_clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_accept) wr_ptr <= next_ptr(wr_ptr);
            if (rd_accept) rd_ptr <= next_ptr(rd_ptr);
            case ({wr_accept, rd_accept})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // none or both
            endcase
        end
    end

    // storage and registered read port
    always_ff @(posedge gmii_tx_clk) begin
        if (wr_accept) begin
            mem[wr_ptr] <= wr_data;
        end
        if (rd_en) begin
            rd_data <= rd_empty ? '0 : mem[rd_ptr];    // underrun sends zeros
        end
    end

    assert property (@(posedge gmii_tx_clk) disable iff (reset) rd_en |-> !rd_empty)
        else $error("payload read from empty fifo");

    // a full fifo only leaves full through a read
    assert property (@(posedge gmii_tx_clk) disable iff (reset)
        (wr_full && !rd_accept) |=> wr_full)
        else $error("write accepted while fifo full");

endmodule

// ==== verilog/udp_tx.sv ====
module udp_tx (
    input  logic               gmii_tx_clk,
    input  logic               reset,
    input  logic               tx_start_en,
    input  eth_pkg::byte_cnt_t tx_byte_num,
    output logic               tx_req,       // fifo read, 2 cycles ahead of use
    input  eth_pkg::tx_word_t  tx_data,
    output logic               tx_done,
    output logic               csum_start,
    output eth_pkg::byte_cnt_t csum_len,
    output logic [15:0]        csum_ident,
    input  logic [15:0]        csum,
    input  logic               csum_valid,
    output eth_pkg::gmii_tx_t  gmii_tx
);
    import eth_pkg::*;

    tx_state_t   state;
    byte_cnt_t   cnt;           // byte index inside current section
    byte_cnt_t   byte_num_q;    // payload bytes of this frame
    byte_cnt_t   pad_len;
    byte_cnt_t   ip_len;
    byte_cnt_t   udp_len;
    logic [15:0] ident_q;       // per-frame ip identification
    logic [15:0] csum_q;
    logic        sec_last;      // last byte of section this cycle
    logic        en_nxt;
    logic [7:0]  byte_nxt;
    logic        crc_en;
    crc_t        crc;

    logic [8*MAC_HDR_LEN-1:0] mac_hdr;
    logic [8*IP_HDR_LEN-1:0]  ip_hdr;
    logic [8*UDP_HDR_LEN-1:0] udp_hdr;

    // ********************
    // checksum handoff
    // ********************
    assign csum_start = tx_start_en && (state == ST_IDLE);   // busy drops the pulse
    assign csum_len   = tx_byte_num + IP_HDR_LEN + UDP_HDR_LEN;
    assign csum_ident = ident_q;

    // length fields carry the true count, padding not included
    assign ip_len  = byte_num_q + IP_HDR_LEN + UDP_HDR_LEN;
    assign udp_len = byte_num_q + UDP_HDR_LEN;
    assign pad_len = (byte_num_q < MIN_PAYLOAD) ? MIN_PAYLOAD - byte_num_q : '0;

    // headers as flat byte strings, first byte in the msbs
    assign mac_hdr = {DES_MAC, BOARD_MAC, ETH_TYPE_IPV4};
    assign ip_hdr  = {IP_VER_IHL, 8'h00, ip_len, ident_q, IP_FLAGS,
                      IP_TTL, IP_PROTO_UDP, csum_q, BOARD_IP, DES_IP};
    assign udp_hdr = {BOARD_PORT, DES_PORT, udp_len, 16'h0000};    // udp csum unused

    // word fetch: cycle before byte 0 of each word is selected
    assign tx_req = ((state == ST_UDP_HDR) && (cnt == UDP_HDR_LEN - 1'b1)
                        && (byte_num_q != '0))
                 || ((state == ST_PAYLOAD) && (cnt[1:0] == 2'd3)
                        && (cnt + 1'b1 < byte_num_q));

    // ********************
    // next byte select
    // ********************
    always_comb begin
        en_nxt   = 1'b1;
        byte_nxt = 8'h00;
        crc_en   = 1'b0;
        sec_last = 1'b0;
        case (state)
            ST_CSUM: begin
                en_nxt   = csum_valid;      // first preamble byte leaves with csum
                byte_nxt = PREAMBLE_BYTE;
            end
            ST_PREAMBLE: begin
                sec_last = (cnt == PREAMBLE_LEN - 1'b1);
                byte_nxt = sec_last ? SFD_BYTE : PREAMBLE_BYTE;
            end
            ST_MAC_HDR: begin
                byte_nxt = mac_hdr[8*(MAC_HDR_LEN - 1'b1 - cnt) +: 8];
                crc_en   = 1'b1;
                sec_last = (cnt == MAC_HDR_LEN - 1'b1);
            end
            ST_IP_HDR: begin
                byte_nxt = ip_hdr[8*(IP_HDR_LEN - 1'b1 - cnt) +: 8];
                crc_en   = 1'b1;
                sec_last = (cnt == IP_HDR_LEN - 1'b1);
            end
            ST_UDP_HDR: begin
                byte_nxt = udp_hdr[8*(UDP_HDR_LEN - 1'b1 - cnt) +: 8];
                crc_en   = 1'b1;
                sec_last = (cnt == UDP_HDR_LEN - 1'b1);
            end
            ST_PAYLOAD: begin
                byte_nxt = tx_data[8*(3 - cnt[1:0]) +: 8];     // msb first
                crc_en   = 1'b1;
                sec_last = (cnt == byte_num_q - 1'b1);
            end
            ST_PAD: begin
                crc_en   = 1'b1;                               // zeros
                sec_last = (cnt == pad_len - 1'b1);
            end
            ST_FCS: begin
                byte_nxt = crc[8*cnt[1:0] +: 8];               // lsb byte first
                sec_last = (cnt == FCS_LEN - 1'b1);
            end
            ST_GAP: begin
                en_nxt   = 1'b0;
                sec_last = (cnt == IFG_CYCLES);
            end
            default: en_nxt = 1'b0;                            // idle
        endcase
    end

    // ********************
    // fsm and output reg
    // ********************
    always_ff @(posedge gmii_tx_clk) begin
        if (reset) begin
            state   <= ST_IDLE;
            cnt     <= '0;
            ident_q <= '0;
            tx_done <= 1'b0;
            gmii_tx <= '0;
        end else begin
            gmii_tx.en   <= en_nxt;
            gmii_tx.data <= en_nxt ? byte_nxt : 8'h00;
            tx_done      <= (state == ST_GAP) && (cnt == '0);  // after last fcs byte

            if (state == ST_IDLE) begin
                cnt <= '0;
            end else if (state == ST_CSUM) begin
                cnt <= {15'd0, csum_valid};     // byte 0 already sent
            end else begin
                cnt <= sec_last ? '0 : cnt + 1'b1;
            end

            case (state)
                ST_IDLE: if (tx_start_en) state <= ST_CSUM;
                ST_CSUM: if (csum_valid) state <= ST_PREAMBLE;
                default: begin
                    if (sec_last) begin
                        case (state)
                            ST_PREAMBLE: state <= ST_MAC_HDR;
                            ST_MAC_HDR:  state <= ST_IP_HDR;
                            ST_IP_HDR:   state <= ST_UDP_HDR;
                            ST_UDP_HDR:  state <= (byte_num_q != '0) ? ST_PAYLOAD : ST_PAD;
                            ST_PAYLOAD:  state <= (pad_len != '0) ? ST_PAD : ST_FCS;
                            ST_PAD:      state <= ST_FCS;
                            ST_FCS: begin
                                state   <= ST_GAP;
                                ident_q <= ident_q + 16'd1;   // next frame's id
                            end
                            default:     state <= ST_IDLE;   // end of gap
                        endcase
                    end
                end
            endcase
        end
    end

    // frame parameters, loaded once per frame
    always_ff @(posedge gmii_tx_clk) begin
        if (csum_start) begin
            byte_num_q <= tx_byte_num;
        end
        if ((state == ST_CSUM) && csum_valid) begin
            csum_q <= csum;
        end
    end

    // fcs over mac header through padding
    crc32_d8 u_crc32_d8 (
        .gmii_tx_clk (gmii_tx_clk),
        .reset       (reset),
        .clear       (state == ST_CSUM),
        .data_valid  (crc_en),
        .data        (byte_nxt),
        .crc         (crc)
    );

    // en only ever ends a frame together with tx_done
    assert property (@(posedge gmii_tx_clk) disable iff (reset) $fell(gmii_tx.en) |-> tx_done)
        else $error("gmii_tx.en dropped mid-frame");

endmodule

// ==== verilog/eth_udp_send.sv ====
module eth_udp_send (
    input  logic               gmii_tx_clk,
    input  logic               reset,
    // user side
    input  logic               wr_en,
    input  eth_pkg::tx_word_t  wr_data,
    output logic               wr_full,
    input  logic               tx_start_en,
    input  eth_pkg::byte_cnt_t tx_byte_num,
    output logic               tx_done,
    // phy side
    output eth_pkg::gmii_tx_t  gmii_tx
);
    import eth_pkg::*;

    logic        tx_req;        // builder word fetch
    tx_word_t    tx_data;
    logic        csum_start;
    byte_cnt_t   csum_len;
    logic [15:0] csum_ident;
    logic [15:0] csum;
    logic        csum_valid;

    // ********************
    // payload buffer
    // ********************
    tx_word_fifo u_tx_word_fifo (
        .gmii_tx_clk (gmii_tx_clk),
        .reset       (reset),
        .wr_en       (wr_en),
        .wr_data     (wr_data),
        .wr_full     (wr_full),
        .rd_en       (tx_req),
        .rd_data     (tx_data),
        .rd_empty    ()                 // underrun checked inside the fifo
    );

    ip_checksum u_ip_checksum (
        .gmii_tx_clk (gmii_tx_clk),
        .reset       (reset),
        .start       (csum_start),
        .total_len   (csum_len),
        .ident       (csum_ident),
        .csum        (csum),
        .csum_valid  (csum_valid)
    );

    // frame builder
    udp_tx u_udp_tx (
        .gmii_tx_clk (gmii_tx_clk),
        .reset       (reset),
        .tx_start_en (tx_start_en),
        .tx_byte_num (tx_byte_num),
        .tx_req      (tx_req),
        .tx_data     (tx_data),
        .tx_done     (tx_done),
        .csum_start  (csum_start),
        .csum_len    (csum_len),
        .csum_ident  (csum_ident),
        .csum        (csum),
        .csum_valid  (csum_valid),
        .gmii_tx     (gmii_tx)
    );

endmodule

// ==== tb/frame_model.svh ====
`ifndef FRAME_MODEL_SVH
`define FRAME_MODEL_SVH

typedef logic [7:0] byte_q_t[$];
typedef tx_word_t   word_q_t[$];

// ********************
// reference checksums
// ********************
// ones' complement over 16-bit halfwords, big endian
function automatic logic [15:0] header_checksum(input byte_q_t hdr);
    logic [31:0] sum;
    sum = '0;
    for (int i = 0; i + 1 < hdr.size(); i += 2) begin
        sum = sum + {16'd0, hdr[i], hdr[i + 1]};
    end
    while (sum[31:16] != 16'd0) begin
        sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};   // end-around carry
    end
    return ~sum[15:0];
endfunction

// ieee 802.3 crc, lsb first, value as sent
function automatic logic [31:0] frame_crc(input byte_q_t data);
    logic [31:0] c;
    c = 32'hffff_ffff;
    foreach (data[i]) begin
        c = c ^ {24'd0, data[i]};
        for (int k = 0; k < 8; k++) begin
            c = c[0] ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
        end
    end
    return ~c;
endfunction

// ********************
// expected frame
// ********************
// every byte seen on gmii while en is high
function automatic void build_frame(
    input  int          count,
    input  logic [15:0] ident,
    input  word_q_t     words,
    output byte_q_t     frame
);
    byte_q_t     body;      // crc coverage, mac header through pad
    byte_q_t     ip;
    logic [15:0] ip_len;
    logic [15:0] udp_len;
    logic [15:0] csum;
    logic [31:0] fcs;
    ip_len  = 16'(count + 28);     // true count, no pad
    udp_len = 16'(count + 8);
    frame.delete();
    for (int i = 5; i >= 0; i--) body.push_back(DES_MAC[8*i +: 8]);
    for (int i = 5; i >= 0; i--) body.push_back(BOARD_MAC[8*i +: 8]);
    body.push_back(8'h08);
    body.push_back(8'h00);
    ip = '{8'h45, 8'h00, ip_len[15:8], ip_len[7:0], ident[15:8], ident[7:0],
           8'h40, 8'h00, 8'd64, 8'd17, 8'h00, 8'h00};
    for (int i = 3; i >= 0; i--) ip.push_back(BOARD_IP[8*i +: 8]);
    for (int i = 3; i >= 0; i--) ip.push_back(DES_IP[8*i +: 8]);
    csum   = header_checksum(ip);
    ip[10] = csum[15:8];
    ip[11] = csum[7:0];
    foreach (ip[i]) body.push_back(ip[i]);
    body.push_back(BOARD_PORT[15:8]);
    body.push_back(BOARD_PORT[7:0]);
    body.push_back(DES_PORT[15:8]);
    body.push_back(DES_PORT[7:0]);
    body.push_back(udp_len[15:8]);
    body.push_back(udp_len[7:0]);
    body.push_back(8'h00);          // udp checksum unused
    body.push_back(8'h00);
    for (int i = 0; i < count; i++) body.push_back(words[i / 4][8*(3 - i % 4) +: 8]);
    for (int i = count; i < int'(MIN_PAYLOAD); i++) body.push_back(8'h00);
    fcs = frame_crc(body);
    repeat (7) frame.push_back(8'h55);
    frame.push_back(8'hd5);
    foreach (body[i]) frame.push_back(body[i]);
    for (int i = 0; i < 4; i++) frame.push_back(fcs[8*i +: 8]);   // low byte first
endfunction

`endif

// ==== tb/tb_eth_udp_send.sv ====
module tb_eth_udp_send;
    import eth_pkg::*;

    localparam int DEPTH      = 512;            // fifo default
    localparam int NUM_RANDOM = 24;
    localparam int NUM_DRAIN  = DEPTH / 16;     // 64-byte frames empty a full fifo
    localparam int NUM_FRAMES = NUM_RANDOM + NUM_DRAIN + 1;
    localparam int MAX_FRAME  = 8 + 42 + 64 + 4;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * (MAX_FRAME + 100) + 2 * DEPTH + 2000;

    `include "frame_model.svh"

    logic       gmii_tx_clk;
    logic       reset;
    logic       wr_en;
    tx_word_t   wr_data;
    logic       wr_full;
    logic       tx_start_en;
    byte_cnt_t  tx_byte_num;
    logic       tx_done;
    gmii_tx_t   gmii_tx;

    integer      seed;
    int          errors;
    int          cycles;
    int          frames_sent;
    int          frames_seen;   // rising edges of en
    int          done_seen;
    logic        en_q;
    logic [15:0] ident_model;
    byte_q_t     cap;           // bytes of current frame
    word_q_t     exp_words;     // mirror of fifo contents
    int          corner[4] = '{1, 17, 18, 64};
    int          count;

    eth_udp_send DUT (
        .gmii_tx_clk (gmii_tx_clk),
        .reset       (reset),
        .wr_en       (wr_en),
        .wr_data     (wr_data),
        .wr_full     (wr_full),
        .tx_start_en (tx_start_en),
        .tx_byte_num (tx_byte_num),
        .tx_done     (tx_done),
        .gmii_tx     (gmii_tx)
    );

    initial gmii_tx_clk = 1'b0;
    always #2 gmii_tx_clk = ~gmii_tx_clk;

    // ********************
    // monitor and watchdog
    // ********************
    always @(posedge gmii_tx_clk) begin
        if (reset) begin
            en_q <= 1'b0;
        end else begin
            if (gmii_tx.en) cap.push_back(gmii_tx.data);
            if (gmii_tx.en && !en_q) frames_seen++;     // frame start
            if (tx_done) done_seen++;
            en_q <= gmii_tx.en;
        end
    end

    always @(posedge gmii_tx_clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: DUT did not finish its frames within %0d cycles", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end
    endtask

    // byte offset to frame field, for error lines
    function automatic string field_name(input int idx, input int cnt);
        if (idx < 8) return "preamble/sfd";
        if (idx < 22) return "mac header";
        if (idx == 26 || idx == 27) return "ip ident";
        if (idx == 32 || idx == 33) return "ip checksum";
        if (idx < 42) return "ip header";
        if (idx < 50) return "udp header";
        if (idx < 50 + cnt) return "payload";
        if (idx < 50 + int'(MIN_PAYLOAD)) return "pad";
        return "fcs";
    endfunction

    task automatic load_words(input int n);
        tx_word_t w;
        for (int i = 0; i < n; i++) begin
            w = $random(seed);
            @(posedge gmii_tx_clk);
            #1;
            wr_en   = 1'b1;
            wr_data = w;
            if (exp_words.size() < DEPTH) exp_words.push_back(w);   // full drops it
        end
        @(posedge gmii_tx_clk);
        #1;
        wr_en = 1'b0;
    endtask

    // one frame start to end of gap; stray adds ignored start pulses
    task automatic send_frame(input int cnt, input bit stray);
        word_q_t words;
        byte_q_t expect_q;
        string   tag;
        tag = $sformatf("frame %0d", frames_sent);
        for (int i = 0; i < (cnt + 3) / 4; i++) words.push_back(exp_words.pop_front());
        build_frame(cnt, ident_model, words, expect_q);
        ident_model++;
        cap.delete();
        @(posedge gmii_tx_clk);
        #1;
        tx_start_en = 1'b1;
        tx_byte_num = byte_cnt_t'(cnt);
        @(posedge gmii_tx_clk);
        #1;
        tx_start_en = 1'b0;
        frames_sent++;
        if (stray) begin
            do @(posedge gmii_tx_clk); while (!gmii_tx.en);
            #1;
            tx_start_en = 1'b1;            // mid-frame, must be ignored
            tx_byte_num = 16'd5;
            @(posedge gmii_tx_clk);
            #1;
            tx_start_en = 1'b0;
        end
        do @(posedge gmii_tx_clk); while (!tx_done);
        check({tag, " en low at tx_done"}, 0, gmii_tx.en);
        check({tag, " tx_done right after last byte"}, 1, en_q);   // en high the cycle before
        check({tag, " length"}, expect_q.size(), cap.size());
        foreach (expect_q[i]) begin
            if (i < cap.size()) begin
                check($sformatf("%s %s byte %0d", tag, field_name(i, cnt), i),
                      expect_q[i], cap[i]);
            end
        end
        if (stray) begin
            #1;
            tx_start_en = 1'b1;            // inside the gap
        end
        @(posedge gmii_tx_clk);
        check({tag, " tx_done single cycle"}, 0, tx_done);
        #1;
        tx_start_en = 1'b0;
        repeat (IFG_CYCLES + 2) @(posedge gmii_tx_clk);
    endtask

    // ********************
    // test sequence
    // ********************
    initial begin
        seed        = 32'h594a50cf;
        reset       = 1'b1;
        wr_en       = 1'b0;
        wr_data     = '0;
        tx_start_en = 1'b0;
        tx_byte_num = '0;
        errors      = 0;
        cycles      = 0;
        frames_sent = 0;
        frames_seen = 0;
        done_seen   = 0;
        ident_model = '0;
        repeat (5) @(posedge gmii_tx_clk);
        #1;
        reset = 1'b0;
        check("reset gmii en", 0, gmii_tx.en);
        check("reset tx_done", 0, tx_done);
        check("reset wr_full", 0, wr_full);

        for (int t = 0; t < NUM_RANDOM; t++) begin
            count = (t < 4) ? corner[t] : 1 + ($unsigned($random(seed)) % 64);
            load_words((count + 3) / 4);
            send_frame(count, (t % 5) == 2);
        end

        // fill fifo, then one write that must be dropped
        load_words(DEPTH);
        check("fifo full after depth writes", 1, wr_full);
        load_words(1);
        check("fifo still full", 1, wr_full);
        for (int t = 0; t < NUM_DRAIN; t++) send_frame(64, 1'b0);
        check("fifo no longer full", 0, wr_full);
        count = 1 + ($unsigned($random(seed)) % 64);
        load_words((count + 3) / 4);
        send_frame(count, 1'b1);

        repeat (40) @(posedge gmii_tx_clk);     // room for a wrong extra frame
        check("frames on gmii", frames_sent, frames_seen);
        check("tx_done pulses", frames_sent, done_seen);

        $display("%0d frames sent, %0d errors", frames_sent, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+tb
verilog/eth_pkg.sv
verilog/crc32_d8.sv
verilog/ip_checksum.sv
verilog/tx_word_fifo.sv
verilog/udp_tx.sv
verilog/eth_udp_send.sv
tb/tb_eth_udp_send.sv

// ==== Bender.yml ====
package:
  name: eth_udp_send

sources:
  - files:
      - verilog/eth_pkg.sv
      - verilog/crc32_d8.sv
      - verilog/ip_checksum.sv
      - verilog/tx_word_fifo.sv
      - verilog/udp_tx.sv
      - verilog/eth_udp_send.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_eth_udp_send.sv
